// ==== tb.f ====
mmu_pkg.sv
mmu_slot.sv
mmu_table_load.sv
mmu_walk_ctrl.sv
mmu_walker_top.sv
tb_page_mem.sv
tb_mmu_walker.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps
TOP ?= tb_mmu_walker
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT = No errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_mmu_walker.sv ====
`timescale 1ns/1ps

module tb_mmu_walker;

	localparam int EXTRA_REQS = 7;      // Requests of the directed tests after the table.
	localparam int HOLD_CYCLES = 40;

	typedef struct {
		string name;
		logic [31:0] root;
		logic [31:0] vaddr;
		logic [63:0] l1_pair;
		logic [63:0] l2_pair;
		mmu_pkg::mmu_result_t exp;
	} walk_case_t;

	logic iCLOCK;
	logic inRESET;
	logic reset_sync;
	logic req_valid;
	mmu_pkg::mmu_req_t req;
	logic req_busy;
	logic result_read;
	logic result_full;
	mmu_pkg::mmu_result_t result;
	logic mem_req;
	mmu_pkg::mmu_mem_rd_t mem_rd;
	logic mem_lock;
	logic mem_valid;
	logic [63:0] mem_data;
	walk_case_t cases[$];
	int cycle_count = 0;
	int max_cycles = 0;

	mmu_walker_top mmu_walker_top_inst (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.reset_sync  (reset_sync),
		.req_valid   (req_valid),
		.req         (req),
		.req_busy    (req_busy),
		.result_read (result_read),
		.result_full (result_full),
		.result      (result),
		.mem_req     (mem_req),
		.mem_rd      (mem_rd),
		.mem_lock    (mem_lock),
		.mem_valid   (mem_valid),
		.mem_data    (mem_data)
	);

	tb_page_mem page_mem (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.mem_req   (mem_req),
		.mem_rd    (mem_rd),
		.mem_lock  (mem_lock),
		.mem_valid (mem_valid),
		.mem_data  (mem_data)
	);

	initial iCLOCK = 1'b0;
	always #5 iCLOCK = ~iCLOCK;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	always @(posedge iCLOCK) begin
		cycle_count <= cycle_count + 1;
		if (max_cycles != 0 && cycle_count >= max_cycles) begin
			report_failure($sformatf("Timeout, the run did not end within %0d cycles", max_cycles));
		end
	end

	function automatic logic [31:0] l1_addr_of(input logic [31:0] root, input logic [31:0] vaddr);
		return root + {20'b0, vaddr[31:22], 2'b00};
	endfunction

	function automatic logic [31:0] l2_addr_of(input logic [31:0] entry, input logic [31:0] vaddr);
		return {entry[31:12], 12'b0} + {20'b0, vaddr[21:12], 2'b00};
	endfunction

	function automatic logic [31:0] pick_entry(input logic [63:0] pair, input logic [31:0] addr);
		return addr[2] ? pair[63:32] : pair[31:0];
	endfunction

	function automatic mmu_pkg::mmu_result_t expected_walk(input logic [31:0] root,
		input logic [31:0] vaddr, input logic [63:0] l1_pair, input logic [63:0] l2_pair);
		logic [31:0] l1_entry;
		logic [31:0] l2_entry;
		mmu_pkg::mmu_result_t r;
		r = '0;
		l1_entry = pick_entry(l1_pair, l1_addr_of(root, vaddr));
		if (!l1_entry[0]) begin
			r.fault = 1'b1;                      // Level 0, address and flags stay zero.
			return r;
		end
		l2_entry = pick_entry(l2_pair, l2_addr_of(l1_entry, vaddr));
		if (!l2_entry[0]) begin
			r.fault = 1'b1;
			r.fault_level = 1'b1;
			return r;
		end
		r.paddr = {l2_entry[31:12], vaddr[11:0]};
		r.flags_even = l2_pair[11:0];
		r.flags_odd = l2_pair[43:32];
		return r;
	endfunction

	function automatic string format_result(input mmu_pkg::mmu_result_t r);
		return $sformatf("paddr=%h fault=%0b level=%0b even=%h odd=%h",
			r.paddr, r.fault, r.fault_level, r.flags_even, r.flags_odd);
	endfunction

	task automatic add_case(input string name, input logic [31:0] root, input logic [31:0] vaddr,
		input logic [63:0] l1_pair, input logic [63:0] l2_pair);
		walk_case_t c;
		c.name = name;
		c.root = root;
		c.vaddr = vaddr;
		c.l1_pair = l1_pair;
		c.l2_pair = l2_pair;
		c.exp = expected_walk(root, vaddr, l1_pair, l2_pair);
		cases.push_back(c);
	endtask

	task automatic check_result(input string name, input mmu_pkg::mmu_result_t exp,
		input mmu_pkg::mmu_result_t act);
		if (act !== exp) begin
			report_failure($sformatf("ERR %s expected %s actual %s", name,
				format_result(exp), format_result(act)));
		end
	endtask

	task automatic check_busy(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			report_failure($sformatf("ERR %s req_busy expected %0b actual %0b", name, exp, act));
		end
	endtask

	task automatic check_full(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			report_failure($sformatf("ERR %s result_full expected %0b actual %0b", name, exp, act));
		end
	endtask

	task automatic load_case(input walk_case_t c);
		logic [31:0] l1_entry;
		l1_entry = pick_entry(c.l1_pair, l1_addr_of(c.root, c.vaddr));
		page_mem.write_pair(l1_addr_of(c.root, c.vaddr), c.l1_pair);
		if (l1_entry[0]) begin
			page_mem.write_pair(l2_addr_of(l1_entry, c.vaddr), c.l2_pair);
		end
	endtask

	task automatic submit_request(input walk_case_t c);
		while (req_busy) begin
			@(posedge iCLOCK);
			#1;
		end
		req_valid = 1'b1;
		req.vaddr = c.vaddr;
		req.root_base = c.root;
		@(posedge iCLOCK);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic wait_result();
		while (!result_full) begin
			@(posedge iCLOCK);
			#1;
		end
	endtask

	task automatic read_result();
		result_read = 1'b1;
		@(posedge iCLOCK);
		#1;
		result_read = 1'b0;
	endtask

	initial begin
		inRESET = 1'b0;
		reset_sync = 1'b0;
		req_valid = 1'b0;
		req = '0;
		result_read = 1'b0;

		add_case("valid_odd_index", 32'h0001_0000, 32'h0040_3ABC,
			{32'h0002_0001, 32'h0009_9F00}, {32'hABCD_E0C7, 32'h5555_5A31});
		add_case("valid_even_index", 32'h0001_0000, 32'h0080_8123,
			{32'hFFFF_F001, 32'h0003_0003}, {32'h7777_7FFF, 32'h8642_0105});
		add_case("l1_invalid", 32'h0004_0000, 32'hFFC0_0000,
			{32'h0005_0000, 32'h0005_0001}, 64'h0);
		add_case("l2_invalid", 32'h0001_0000, 32'h0C00_5000,
			{32'h0000_0000, 32'h0006_0801}, {32'h1234_5FFE, 32'h1234_5FFF});
		add_case("both_halves_valid", 32'h0008_0000, 32'h0141_7FFF,
			{32'h000A_1001, 32'h000B_2001}, {32'hFEDC_B3A5, 32'h0123_4C5B});
		max_cycles = 40 * (cases.size() + EXTRA_REQS) + 100;

		repeat (5) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		@(posedge iCLOCK);
		#1;
		check_busy("after_reset", 1'b0, req_busy);
		check_full("after_reset", 1'b0, result_full);

		foreach (cases[i]) begin
			load_case(cases[i]);
			submit_request(cases[i]);
			check_busy(cases[i].name, 1'b1, req_busy);
			wait_result();
			check_result(cases[i].name, cases[i].exp, result);
			read_result();
		end

		// Three in flight: one in the result slot, one held by the walker, one queued.
		submit_request(cases[0]);
		submit_request(cases[1]);
		submit_request(cases[3]);
		wait_result();
		repeat (HOLD_CYCLES) begin
			check_busy("backpressure_hold", 1'b1, req_busy);
			check_full("backpressure_hold", 1'b1, result_full);
			@(posedge iCLOCK);
			#1;
		end
		check_result("backpressure_first", cases[0].exp, result);
		read_result();
		wait_result();
		check_result("backpressure_second", cases[1].exp, result);
		read_result();
		wait_result();
		check_result("backpressure_third", cases[3].exp, result);
		read_result();

		// Flush with a result unread, a walk running and a request waiting.
		submit_request(cases[0]);
		wait_result();
		submit_request(cases[1]);
		submit_request(cases[3]);
		check_busy("before_flush", 1'b1, req_busy);
		check_full("before_flush", 1'b1, result_full);
		reset_sync = 1'b1;
		@(posedge iCLOCK);
		#1;
		reset_sync = 1'b0;
		repeat (10) begin
			check_busy("flush", 1'b0, req_busy);
			check_full("flush", 1'b0, result_full);
			@(posedge iCLOCK);
			#1;
		end
		load_case(cases[4]);
		submit_request(cases[4]);
		wait_result();
		check_result("after_flush", cases[4].exp, result);
		read_result();

		$display("No errors");
		$finish;
	end

endmodule

// ==== tb_page_mem.sv ====
`timescale 1ns/1ps

module tb_page_mem (
	input  logic                 iCLOCK,
	input  logic                 inRESET,
	input  logic                 mem_req,
	input  mmu_pkg::mmu_mem_rd_t mem_rd,
	output logic                 mem_lock,
	output logic                 mem_valid,
	output logic [63:0]          mem_data
);

	localparam int LATENCY = 3;
	localparam int SEED = 71233;

	logic [63:0] words [logic [28:0]];  // Sparse, one entry pair per word.
	logic lock_rand;
	logic [28:0] addr_q;
	int wait_q;

	task automatic write_pair(input logic [31:0] addr, input logic [63:0] data);
		words[addr[31:3]] = data;
	endtask

	function automatic logic [63:0] read_pair(input logic [28:0] waddr);
		logic [31:0] byte_addr;
		byte_addr = {waddr, 3'b000};
		if (words.exists(waddr)) begin
			return words[waddr];
		end
		return {~byte_addr, byte_addr};     // Unwritten words.
	endfunction

	initial begin
		void'($urandom(SEED));
		lock_rand = 1'b0;
		forever begin
			@(posedge iCLOCK);
			lock_rand <= (($urandom % 4) == 0); // About one cycle in four.
		end
	end

	// Also locked while a read is outstanding.
	assign mem_lock = lock_rand || (wait_q != 0);

	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wait_q <= 0;
			mem_valid <= 1'b0;
			mem_data <= '0;
			addr_q <= '0;
		end
		else begin
			mem_valid <= 1'b0;
			if (wait_q != 0) begin
				wait_q <= wait_q - 1;
				if (wait_q == 1) begin
					mem_valid <= 1'b1;
					mem_data <= read_pair(addr_q);
				end
			end
			else if (mem_req && !mem_lock) begin
				addr_q <= mem_rd.addr[31:3];
				wait_q <= LATENCY - 1;
			end
		end
	end

endmodule

// ==== mmu_walker_top.sv ====
`timescale 1ns/1ps

module mmu_walker_top (
	input  logic                      iCLOCK,
	input  logic                      inRESET,
	input  logic                      reset_sync,
	input  logic                      req_valid,
	input  mmu_pkg::mmu_req_t         req,
	output logic                      req_busy,
	input  logic                      result_read,
	output logic                      result_full,
	output mmu_pkg::mmu_result_t      result,
	output logic                      mem_req,
	output mmu_pkg::mmu_mem_rd_t      mem_rd,
	input  logic                      mem_lock,
	input  logic                      mem_valid,
	input  logic [63:0]               mem_data
);

	mmu_pkg::mmu_req_t walk_req;
	mmu_pkg::mmu_load_t ld_done;
	mmu_pkg::mmu_result_t walk_res;
	logic take;
	logic ld_req;
	logic [31:0] ld_addr;
	logic ld_busy;
	logic ld_done_valid;
	logic res_valid;

	// Input side. Full doubles as the busy level.
	mmu_slot #(.T(mmu_pkg::mmu_req_t)) req_slot (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.fill       (req_valid),
		.fill_data  (req),
		.drain      (take),
		.full       (req_busy),
		.data       (walk_req)
	);

	mmu_walk_ctrl walk_ctrl (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.req_full   (req_busy),
		.req        (walk_req),
		.take       (take),
		.ld_req     (ld_req),
		.ld_addr    (ld_addr),
		.ld_busy    (ld_busy),
		.done_valid (ld_done_valid),
		.done       (ld_done),
		.res_full   (result_full),
		.res_valid  (res_valid),
		.res        (walk_res)
	);

	mmu_table_load table_load (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.ld_req     (ld_req),
		.ld_addr    (ld_addr),
		.ld_busy    (ld_busy),
		.mem_req    (mem_req),
		.mem_rd     (mem_rd),
		.mem_lock   (mem_lock),
		.mem_valid  (mem_valid),
		.mem_data   (mem_data),
		.done_valid (ld_done_valid),
		.done       (ld_done)
	);

	// Output side.
	mmu_slot #(.T(mmu_pkg::mmu_result_t)) res_slot (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.reset_sync (reset_sync),
		.fill       (res_valid),
		.fill_data  (walk_res),
		.drain      (result_read),
		.full       (result_full),
		.data       (result)
	);

endmodule

// ==== mmu_walk_ctrl.sv ====
`timescale 1ns/1ps

module mmu_walk_ctrl (
	input  logic                      iCLOCK,
	input  logic                      inRESET,
	input  logic                      reset_sync,
	input  logic                      req_full,
	input  mmu_pkg::mmu_req_t         req,
	output logic                      take,
	output logic                      ld_req,
	output logic [31:0]               ld_addr,
	input  logic                      ld_busy,
	input  logic                      done_valid,
	input  mmu_pkg::mmu_load_t        done,
	input  logic                      res_full,
	output logic                      res_valid,
	output mmu_pkg::mmu_result_t      res
);

	typedef enum logic [2:0] {
		W_IDLE,
		W_WAIT1,
		W_REQ2,
		W_WAIT2,
		W_HOLD
	} walk_state_t;

	walk_state_t state_q;
	logic [31:0] vaddr_q;
	logic [31:0] l2_addr_q;
	mmu_pkg::mmu_result_t res_q;

	logic [31:0] l1_addr;
	logic [31:0] l2_addr;
	logic [31:0] pa_base;
	logic [31:0] entry_base;
	logic entry_ok;
	logic start;
	logic l1_done;
	logic l2_done;

	// Level one indexes by the top bits, level two by the bits above the offset.
	assign l1_addr = req.root_base
		+ 32'(req.vaddr[31 -: mmu_pkg::IDX_BITS]) * 32'(mmu_pkg::ENTRY_BYTES);
	assign entry_base = {done.entry[31:mmu_pkg::PAGE_BITS], {mmu_pkg::PAGE_BITS{1'b0}}};
	assign l2_addr = entry_base
		+ 32'(vaddr_q[mmu_pkg::PAGE_BITS +: mmu_pkg::IDX_BITS])
		* 32'(mmu_pkg::ENTRY_BYTES);
	assign pa_base = entry_base;
	assign entry_ok = done.entry[mmu_pkg::PTE_VALID_BIT];

	assign start = (state_q == W_IDLE) && req_full && !ld_busy;
	assign l1_done = (state_q == W_WAIT1) && done_valid;
	assign l2_done = (state_q == W_WAIT2) && done_valid;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= W_IDLE;
		end
		else if (reset_sync) begin
			state_q <= W_IDLE;                   // Abandon the walk.
		end
		else begin
			case (state_q)
				W_IDLE: begin
					if (start) begin
						state_q <= W_WAIT1;
					end
				end
				W_WAIT1: begin
					if (done_valid) begin
						state_q <= entry_ok ? W_REQ2 : W_HOLD;
					end
				end
				W_REQ2: begin
					if (!ld_busy) begin
						state_q <= W_WAIT2;
					end
				end
				W_WAIT2: begin
					if (done_valid) begin
						state_q <= W_HOLD;
					end
				end
				W_HOLD: begin
					if (!res_full) begin
						state_q <= W_IDLE;           // Result handed to the slot.
					end
				end
				default: begin
					state_q <= W_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (start) begin
			vaddr_q <= req.vaddr;
		end
		if (l1_done) begin
			l2_addr_q <= l2_addr;
		end
		if ((l1_done && !entry_ok) || (l2_done && !entry_ok)) begin
			res_q <= '{
				paddr: 32'h0,
				fault: 1'b1,
				fault_level: l2_done,
				flags_even: '0,
				flags_odd: '0
			};
		end
		else if (l2_done) begin
			res_q <= '{
				paddr: {pa_base[31:mmu_pkg::PAGE_BITS], vaddr_q[mmu_pkg::PAGE_BITS-1:0]},
				fault: 1'b0,
				fault_level: 1'b0,
				flags_even: done.flag0,
				flags_odd: done.flag1
			};
		end
	end

	assign take = start;
	assign ld_req = start || ((state_q == W_REQ2) && !ld_busy);
	assign ld_addr = (state_q == W_IDLE) ? l1_addr : l2_addr_q;

	assign res_valid = (state_q == W_HOLD) && !res_full;
	assign res = res_q;

endmodule

// ==== mmu_table_load.sv ====
`timescale 1ns/1ps

module mmu_table_load (
	input  logic                      iCLOCK,
	input  logic                      inRESET,
	input  logic                      reset_sync,
	input  logic                      ld_req,
	input  logic [31:0]               ld_addr,
	output logic                      ld_busy,
	output logic                      mem_req,
	output mmu_pkg::mmu_mem_rd_t      mem_rd,
	input  logic                      mem_lock,
	input  logic                      mem_valid,
	input  logic [63:0]               mem_data,
	output logic                      done_valid,
	output mmu_pkg::mmu_load_t        done
);

	typedef enum logic [1:0] {
		LD_IDLE,
		LD_REQ,
		LD_WAITING
	} ld_state_t;

	ld_state_t state_q;
	logic [31:0] addr_q;

	// A new load starts only from idle.
	wire start = ld_req && (state_q == LD_IDLE);

	always_ff @(posedge iCLOCK) begin
		if (start) begin
			addr_q <= ld_addr;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= LD_IDLE;
		end
		else if (reset_sync) begin
			state_q <= LD_IDLE;
		end
		else begin
			case (state_q)
				LD_IDLE: begin
					if (start) begin
						if (mem_lock) begin
							state_q <= LD_REQ;       // Locked, retry with latched address.
						end
						else begin
							state_q <= LD_WAITING;
						end
					end
				end
				LD_REQ: begin
					if (!mem_lock) begin
						state_q <= LD_WAITING;
					end
				end
				LD_WAITING: begin
					if (mem_valid) begin
						state_q <= LD_IDLE;
					end
				end
				default: begin
					state_q <= LD_IDLE;
				end
			endcase
		end
	end

	assign ld_busy = (state_q != LD_IDLE);

	// First cycle goes straight from ld_addr, later cycles hold the copy.
	assign mem_req = start || (state_q == LD_REQ);
	assign mem_rd.addr = (state_q == LD_REQ) ? addr_q : ld_addr;

	assign done_valid = (state_q == LD_WAITING) && mem_valid;
	assign done.entry = addr_q[2] ? mem_data[63:32] : mem_data[31:0];
	assign done.flag0 = mem_data[11:0];
	assign done.flag1 = mem_data[43:32];

endmodule

// ==== mmu_slot.sv ====
`timescale 1ns/1ps

module mmu_slot #(
	parameter type T = logic [31:0]
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic reset_sync,
	input  logic fill,
	input  T     fill_data,
	input  logic drain,
	output logic full,
	output T     data
);

	logic full_q;
	T data_q;

	wire accept = fill && !full_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			full_q <= 1'b0;
		end
		else if (reset_sync) begin
			full_q <= 1'b0;                  // Flush.
		end
		else if (accept) begin
			full_q <= 1'b1;
		end
		else if (drain) begin
			full_q <= 1'b0;
		end
	end

	// Payload is only meaningful while full.
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			data_q <= fill_data;
		end
	end

	assign full = full_q;
	assign data = data_q;

endmodule

// ==== mmu_pkg.sv ====
package mmu_pkg;

	// Table geometry.
	localparam int PAGE_BITS = 12;       // 4 KiB page offset.
	localparam int IDX_BITS = 10;        // Index width per level.
	localparam int ENTRY_BYTES = 4;      // One 32-bit entry.
	localparam int PTE_VALID_BIT = 0;

	// Translation request from the outside.
	typedef struct packed {
		logic [31:0] vaddr;
		logic [31:0] root_base;
	} mmu_req_t;

	// Read request toward the 64-bit memory port.
	typedef struct packed {
		logic [31:0] addr;               // Bits 2:0 ignored by memory.
	} mmu_mem_rd_t;

	// One loaded entry pair.
	typedef struct packed {
		logic [31:0] entry;              // Entry picked by address bit 2.
		logic [PAGE_BITS-1:0] flag0;     // Memory bits 11:0.
		logic [PAGE_BITS-1:0] flag1;     // Memory bits 43:32.
	} mmu_load_t;

	// Finished translation.
	typedef struct packed {
		logic [31:0] paddr;
		logic fault;
		logic fault_level;               // 0 first level, 1 second level.
		logic [PAGE_BITS-1:0] flags_even;
		logic [PAGE_BITS-1:0] flags_odd;
	} mmu_result_t;

endpackage
